// File: Bender.yml
package:
  name: neural_layer

sources:
  - include_dirs:
      - include
    files:
      - logic/neuralPkg.sv
      - logic/neuronNode.sv
      - logic/denseLayer.sv
      - logic/layerApbRegs.sv
      - logic/neuralLayerTop.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/neuralLayerTb.sv

// File: include/neural_params.svh
`ifndef NEURAL_PARAMS_SVH
`define NEURAL_PARAMS_SVH

// Layer geometry and number formats
`define NUM_INPUTS 10 // Activations into each neuron
`define NUM_NODES 4 // Neurons in the layer
`define DATA_WIDTH 8 // Activations, weights, biases and results
`define FRAC_BITS 5 // Weight fraction bits
`define ACC_WIDTH 20 // Ten full products plus the scaled bias fit here

// APB bus widths
`define APB_ADDR_WIDTH 12
`define APB_DATA_WIDTH 32

// APB byte address map
`define INPUT_BASE 'h000 // One activation per word
`define CTRL_ADDR 'h040 // Bit 0 start or done, bit 1 busy
`define WEIGHT_BASE 'h100 // First node's weight block
`define WEIGHT_STRIDE 'h40 // Distance between node weight blocks
`define BIAS_OFFSET 'h28 // Bias word inside a node's block
`define RESULT_BASE 'h200 // Read-only results, one per word

`endif

// File: logic/denseLayer.sv
`timescale 1ns/100ps
`default_nettype none
`include "neural_params.svh"

module denseLayer
(
	input wire clk,
	input wire reset,
	input wire inValid,
	input wire neuralPkg::activationT [`NUM_INPUTS-1:0] inputs,
	input wire neuralPkg::weightT [`NUM_NODES-1:0][`NUM_INPUTS-1:0] weights,
	input wire neuralPkg::weightT [`NUM_NODES-1:0] biases,
	output wire neuralPkg::resultT [`NUM_NODES-1:0] results,
	output logic outValid
);
	wire [`NUM_NODES-1:0] nodeValid;

	// Every neuron sees the same activations with its own weight row
	genvar n;
	generate
		for (n = 0; n < `NUM_NODES; n++)
		begin : gNode
			neuronNode neuron
			(
				.clk(clk),
				.reset(reset),
				.inValid(inValid),
				.inputs(inputs),
				.weights(weights[n]),
				.bias(biases[n]),
				.result(results[n]),
				.outValid(nodeValid[n])
			);
		end
	endgenerate

	assign outValid = nodeValid[0]; // All neurons share one latency

	nodesInStep: assert property (@(posedge clk) disable iff (reset)
		nodeValid == {`NUM_NODES{nodeValid[0]}});

endmodule

`default_nettype wire

// File: logic/layerApbRegs.sv
`timescale 1ns/100ps
`default_nettype none
`include "neural_params.svh"

module layerApbRegs
(
	input wire clk,
	input wire reset,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [`APB_ADDR_WIDTH-1:0] paddr,
	input wire [`APB_DATA_WIDTH-1:0] pwdata,
	input wire neuralPkg::resultT [`NUM_NODES-1:0] results,
	input wire outValid,
	output logic [`APB_DATA_WIDTH-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output neuralPkg::activationT [`NUM_INPUTS-1:0] inputs,
	output neuralPkg::weightT [`NUM_NODES-1:0][`NUM_INPUTS-1:0] weights,
	output neuralPkg::weightT [`NUM_NODES-1:0] biases,
	output logic inValid
);
	import neuralPkg::*;

	localparam int ADDR_W = `APB_ADDR_WIDTH;
	localparam int EXT_W = `APB_DATA_WIDTH - `DATA_WIDTH;
	localparam int VECTOR_SPAN = `NUM_INPUTS * 4; // Bytes of one activation or weight vector
	localparam int STRIDE_SHIFT = $clog2(`WEIGHT_STRIDE);

	resultT [`NUM_NODES-1:0] resultRegs;
	logic [1:0] inFlight;
	logic done;
	logic busy;
	logic access;
	logic writeEn;
	logic startWrite;
	logic aligned;
	logic inputHit, ctrlHit, weightRegion, weightHit, biasHit, resultHit;
	logic addrError;
	logic [ADDR_W-1:0] inputOffset, weightOffset, blockOffset, resultOffset;
	logic [ADDR_W-1:0] inputIdx, nodeIdx, weightIdx, resultIdx;
	logic [`APB_DATA_WIDTH-1:0] readData;

	function automatic logic [`APB_DATA_WIDTH-1:0] signExtend(input weightT value);
		return {{EXT_W{value[`DATA_WIDTH-1]}}, value};
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb
	begin
		aligned = paddr[1:0] == 2'b00;
		inputOffset = paddr - ADDR_W'(`INPUT_BASE); // Wraps high below the base
		weightOffset = paddr - ADDR_W'(`WEIGHT_BASE);
		resultOffset = paddr - ADDR_W'(`RESULT_BASE);
		blockOffset = weightOffset & ADDR_W'(`WEIGHT_STRIDE - 1);
		inputIdx = inputOffset >> 2;
		nodeIdx = weightOffset >> STRIDE_SHIFT;
		weightIdx = blockOffset >> 2;
		resultIdx = resultOffset >> 2;
		inputHit = aligned && inputOffset < VECTOR_SPAN;
		ctrlHit = paddr == ADDR_W'(`CTRL_ADDR);
		weightRegion = aligned && weightOffset < `NUM_NODES * `WEIGHT_STRIDE;
		weightHit = weightRegion && blockOffset < VECTOR_SPAN;
		biasHit = weightRegion && blockOffset == ADDR_W'(`BIAS_OFFSET);
		resultHit = aligned && resultOffset < `NUM_NODES * 4;
		addrError = !(inputHit || ctrlHit || weightHit || biasHit || resultHit)
			|| (pwrite && resultHit); // Results are read-only
	end

	assign access = psel && penable;
	assign writeEn = access && pwrite && !addrError;
	assign startWrite = writeEn && ctrlHit && pwdata[0];
	assign busy = inFlight != 2'd0;

	// Operand registers
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputs <= '0;
			weights <= '0;
			biases <= '0;
		end
		else if (writeEn)
		begin
			if (inputHit)
				inputs[inputIdx] <= activationT'(pwdata[`DATA_WIDTH-1:0]);
			if (weightHit)
				weights[nodeIdx][weightIdx] <= weightT'(pwdata[`DATA_WIDTH-1:0]);
			if (biasHit)
				biases[nodeIdx] <= weightT'(pwdata[`DATA_WIDTH-1:0]);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Start pulse, status and result capture
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inValid <= 1'b0;
			done <= 1'b0;
			inFlight <= 2'd0;
			resultRegs <= '0;
		end
		else
		begin
			inValid <= startWrite; // Launches in the cycle after the access phase
			if (outValid)
			begin
				resultRegs <= results;
				done <= 1'b1;
			end
			if (startWrite)
				done <= 1'b0; // A new start wins over an older item finishing
			case ({inValid, outValid})
				2'b10: inFlight <= inFlight + 2'd1;
				2'b01: inFlight <= inFlight - 2'd1;
				default: inFlight <= inFlight;
			endcase
		end
	end

	// Read mux
	always_comb
	begin
		readData = '0;
		if (inputHit)
			readData = signExtend(inputs[inputIdx]);
		else if (ctrlHit)
			readData = {{(`APB_DATA_WIDTH-2){1'b0}}, busy, done};
		else if (weightHit)
			readData = signExtend(weights[nodeIdx][weightIdx]);
		else if (biasHit)
			readData = signExtend(biases[nodeIdx]);
		else if (resultHit)
			readData = {{EXT_W{1'b0}}, resultRegs[resultIdx]};
	end

	assign prdata = (access && !pwrite && !addrError) ? readData : '0;
	assign pready = 1'b1; // No wait states
	assign pslverr = access && addrError;

	addrStable: assert property (@(posedge clk) disable iff (reset)
		access |-> $stable(paddr) && $stable(pwrite));

	errorAfterSetup: assert property (@(posedge clk) disable iff (reset)
		pslverr |-> access && $past(psel && !penable));

endmodule

`default_nettype wire

// File: logic/neuralLayerTop.sv
`timescale 1ns/100ps
`default_nettype none
`include "neural_params.svh"

module neuralLayerTop
(
	input wire clk,
	input wire reset,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [`APB_ADDR_WIDTH-1:0] paddr,
	input wire [`APB_DATA_WIDTH-1:0] pwdata,
	output wire [`APB_DATA_WIDTH-1:0] prdata,
	output wire pready,
	output wire pslverr
);
	import neuralPkg::*;

	wire activationT [`NUM_INPUTS-1:0] layerInputs;
	wire weightT [`NUM_NODES-1:0][`NUM_INPUTS-1:0] layerWeights;
	wire weightT [`NUM_NODES-1:0] layerBiases;
	wire resultT [`NUM_NODES-1:0] layerResults;
	wire layerInValid;
	wire layerOutValid;

	layerApbRegs regs0
	(
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.results(layerResults),
		.outValid(layerOutValid),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.inputs(layerInputs),
		.weights(layerWeights),
		.biases(layerBiases),
		.inValid(layerInValid)
	);

	denseLayer layer0
	(
		.clk(clk),
		.reset(reset),
		.inValid(layerInValid),
		.inputs(layerInputs),
		.weights(layerWeights),
		.biases(layerBiases),
		.results(layerResults),
		.outValid(layerOutValid)
	);

endmodule

`default_nettype wire

// File: logic/neuralPkg.sv
`default_nettype none
`include "neural_params.svh"

package neuralPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Fixed-point number types of the layer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic signed [`DATA_WIDTH-1:0] activationT; // Integer input value

	typedef logic signed [`DATA_WIDTH-1:0] weightT; // Scaled by 2^FRAC_BITS

	typedef logic signed [2*`DATA_WIDTH-1:0] productT; // Full activation times weight

	typedef logic signed [`ACC_WIDTH-1:0] accT; // Sum of products and bias

	typedef logic [`DATA_WIDTH-1:0] resultT; // Output after ReLU and clamp

endpackage

`default_nettype wire

// File: logic/neuronNode.sv
`timescale 1ns/100ps
`default_nettype none
`include "neural_params.svh"

module neuronNode
(
	input wire clk,
	input wire reset,
	input wire inValid,
	input wire neuralPkg::activationT [`NUM_INPUTS-1:0] inputs,
	input wire neuralPkg::weightT [`NUM_INPUTS-1:0] weights,
	input wire neuralPkg::weightT bias,
	output neuralPkg::resultT result,
	output logic outValid
);
	import neuralPkg::*;

	localparam accT MAX_RESULT = accT'((1 << (`DATA_WIDTH - 1)) - 1);

	activationT [`NUM_INPUTS-1:0] inputReg;
	weightT [`NUM_INPUTS-1:0] weightReg;
	weightT biasReg;
	logic captureValid;
	productT [`NUM_INPUTS-1:0] products;
	accT sumNext;
	accT sumReg;
	logic sumValid;
	accT scaled;
	resultT clampNext;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage 1 holds the operands of one item
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputReg <= '0;
			weightReg <= '0;
			biasReg <= '0;
		end
		else if (inValid)
		begin
			inputReg <= inputs;
			weightReg <= weights;
			biasReg <= bias;
		end
	end

	// Stage 2 adds the full products to the bias moved up to the product scale
	always_comb
	begin
		sumNext = accT'(biasReg) <<< `FRAC_BITS;
		for (int i = 0; i < `NUM_INPUTS; i++)
		begin
			products[i] = productT'(inputReg[i]) * productT'(weightReg[i]);
			sumNext = sumNext + accT'(products[i]);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			sumReg <= '0;
		else
			sumReg <= sumNext;
	end

	// Stage 3 drops the fraction bits, then ReLU and saturate
	always_comb
	begin
		scaled = sumReg >>> `FRAC_BITS; // Floor division by 2^FRAC_BITS
		if (scaled < 0)
			clampNext = '0;
		else if (scaled > MAX_RESULT)
			clampNext = resultT'(MAX_RESULT);
		else
			clampNext = resultT'(scaled);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			result <= '0;
		else
			result <= clampNext;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			captureValid <= 1'b0;
			sumValid <= 1'b0;
			outValid <= 1'b0;
		end
		else
		begin
			captureValid <= inValid;
			sumValid <= captureValid;
			outValid <= sumValid;
		end
	end

	validLatency: assert property (@(posedge clk) disable iff (reset)
		inValid |-> ##3 outValid);

endmodule

`default_nettype wire

// File: sim/layer_vectors.txt
// Columns: opcode address data-or-expected test, all hex
// Opcodes: 1 write, 2 read and compare, 3 start and wait, 4 write with PSLVERR, 5 read with PSLVERR
2 040 00000000 01
2 200 00000000 01
2 204 00000000 01
2 208 00000000 01
2 20C 00000000 01
2 1C4 00000000 01
1 000 0000000A 02
1 004 000000FD 02
1 100 00000020 02
1 104 00000010 02
1 128 00000002 02
1 140 000000E0 02
1 180 0000007F 02
1 1A8 0000007F 02
1 1C4 000000C0 02
1 1E8 000000FF 02
2 004 FFFFFFFD 02
2 140 FFFFFFE0 02
2 1E8 FFFFFFFF 02
3 040 00000001 03
2 200 0000000A 03
2 20C 00000005 03
2 204 00000000 04
2 208 0000007F 04
1 000 00000004 05
1 040 00000001 05
1 000 00000014 05
3 040 00000001 05
2 040 00000001 05
2 200 00000014 05
2 204 00000000 05
2 208 0000007F 05
2 20C 00000005 05
4 200 00000055 06
5 080 00000000 06
4 12C 00000011 06
2 200 00000014 06
0 000 00000000 00

// File: sim/neuralLayerTb.sv
`timescale 1ns/100ps
`default_nettype none
`include "neural_params.svh"

module neuralLayerTb;

	localparam int VECTOR_WORDS = 256; // Four words per operation
	localparam int READY_LIMIT = 16;
	localparam int DONE_LIMIT = 50;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`APB_ADDR_WIDTH-1:0] paddr;
	logic [`APB_DATA_WIDTH-1:0] pwdata;
	wire [`APB_DATA_WIDTH-1:0] prdata;
	wire pready;
	wire pslverr;

	logic [31:0] vectors [0:VECTOR_WORDS-1];
	int errorCount;
	int opCount;

	neuralLayerTop dut0
	(
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
			errorCount++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// APB master
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic apbTransfer(input logic write, input logic [`APB_ADDR_WIDTH-1:0] addr,
		input logic [31:0] data, output logic [31:0] readData, output logic error);
		int waitCycles;
		waitCycles = 0;
		@(posedge clk);
		psel <= 1'b1; // Setup phase
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1; // Access phase
		@(negedge clk);
		while (pready !== 1'b1 && waitCycles < READY_LIMIT)
		begin
			@(negedge clk);
			waitCycles++;
		end
		if (pready !== 1'b1)
		begin
			$display("APB transfer to address %h never saw PREADY", addr);
			errorCount++;
		end
		readData = prdata; // Sampled mid-cycle where it is settled
		error = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apbWrite(input logic [`APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
		output logic error);
		logic [31:0] unused;
		apbTransfer(1'b1, addr, data, unused, error);
	endtask

	task automatic apbRead(input logic [`APB_ADDR_WIDTH-1:0] addr, output logic [31:0] data,
		output logic error);
		apbTransfer(1'b0, addr, 32'h0, data, error);
	endtask

	task automatic startAndWait(input string name);
		logic [31:0] status;
		logic error;
		int polls;
		polls = 0;
		status = '0;
		apbWrite(`CTRL_ADDR, 32'h1, error);
		checkValue({name, " start PSLVERR"}, 32'h0, {31'b0, error});
		while (status[0] !== 1'b1 && polls < DONE_LIMIT)
		begin
			apbRead(`CTRL_ADDR, status, error);
			polls++;
		end
		if (status[0] !== 1'b1)
		begin
			$display("In %s the done flag never rose after the start write", name);
			errorCount++;
		end
	endtask

	// One line of the vectors file
	task automatic runOperation(input int index);
		logic [3:0] opcode;
		logic [`APB_ADDR_WIDTH-1:0] addr;
		logic [31:0] data;
		logic [31:0] readData;
		logic error;
		string name;
		opcode = vectors[index][3:0];
		addr = vectors[index+1][`APB_ADDR_WIDTH-1:0];
		data = vectors[index+2];
		name = $sformatf("test %0d at %h", vectors[index+3], addr);
		case (opcode)
			4'h1:
			begin
				apbWrite(addr, data, error);
				checkValue({name, " PSLVERR"}, 32'h0, {31'b0, error});
			end
			4'h2:
			begin
				apbRead(addr, readData, error);
				checkValue({name, " PSLVERR"}, 32'h0, {31'b0, error});
				checkValue(name, data, readData);
			end
			4'h3:
				startAndWait(name);
			4'h4:
			begin
				apbWrite(addr, data, error);
				checkValue({name, " PSLVERR"}, 32'h1, {31'b0, error});
			end
			4'h5:
			begin
				apbRead(addr, readData, error);
				checkValue({name, " PSLVERR"}, 32'h1, {31'b0, error});
				checkValue(name, data, readData); // Erroring reads return zero
			end
			default:
			begin
				$display("Unknown opcode %h on vector line %0d", opcode, index / 4);
				errorCount++;
			end
		endcase
	endtask

	initial
	begin
		int index;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		errorCount = 0;
		opCount = 0;
		for (index = 0; index < VECTOR_WORDS; index++)
			vectors[index] = '0;
		$readmemh("sim/layer_vectors.txt", vectors);
		if (vectors[0] == 32'h0)
		begin
			$display("The vectors file is missing or holds no operations");
			errorCount++;
		end
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		index = 0;
		while (index + 3 < VECTOR_WORDS && vectors[index] != 32'h0) // Opcode 0 ends the list
		begin
			runOperation(index);
			opCount++;
			index += 4;
		end
		$display("Ran %0d operations with %0d errors", opCount, errorCount);
		if (errorCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
logic/neuralPkg.sv
logic/neuronNode.sv
logic/denseLayer.sv
logic/layerApbRegs.sv
logic/neuralLayerTop.sv
sim/neuralLayerTb.sv
